// ==== phs_cal_macros.svh ====
// ==========================================================================
// Phase calibration constants shared by packages and RTL
// ==========================================================================
`ifndef PHS_CAL_MACROS_SVH
`define PHS_CAL_MACROS_SVH

// Complementary pairs, phase i couples with phase i+NUM_PAIRS
`define NUM_PAIRS 4
`define GRAY_W 6
`define EDGE_W 8

`define TRIM_FIFO_DEPTH 4
`define AXIL_ADDR_W 4

`endif

// ==== phs_types_pkg.sv ====
// ==========================================================================
// Phase-domain types: edge positions, gray trim codes, trim commands
// ==========================================================================
`include "phs_cal_macros.svh"

package phs_types_pkg;

  localparam int NUM_PHASES = 2 * `NUM_PAIRS;

  // Edge position in delay units within one 256-unit period
  typedef logic [`EDGE_W-1:0] phs_edge_t;

  typedef phs_edge_t [NUM_PHASES-1:0] phs_vec_t;

  typedef logic [`GRAY_W-1:0] gray_code_t;

  // One queued trim write, 14 bits
  typedef struct packed {
    logic [$clog2(`NUM_PAIRS)-1:0] pair;
    gray_code_t                    r_gray;
    gray_code_t                    f_gray;
  } trim_cmd_t;

endpackage

// ==== axil_types_pkg.sv ====
// ==========================================================================
// AXI4-Lite bus types: response codes and register offsets
// ==========================================================================
`include "phs_cal_macros.svh"

package axil_types_pkg;

  typedef enum logic [1:0] {
    OKAY   = 2'b00,
    SLVERR = 2'b10
  } axil_resp_t;

  typedef enum logic [`AXIL_ADDR_W-1:0] {
    REG_CTRL   = 4'h0,
    REG_TRIM   = 4'h4,
    // Read only
    REG_STATUS = 4'h8
  } axil_reg_e;

endpackage

// ==== io_phs_pair_couple.sv ====
// ==========================================================================
// Pair coupler: optional p/n swap, then gray trim added to each edge
// ==========================================================================
`timescale 1ns/1ns

module io_phs_pair_couple
  import phs_types_pkg::*;
(
  input  phs_edge_t  c_in_p,
  input  phs_edge_t  c_in_n,
  input  logic       phy_clk_phs_ctrl,
  input  logic       cenable,
  input  gray_code_t r_gray,
  input  gray_code_t f_gray,
  output phs_edge_t  c_out_p,
  output phs_edge_t  c_out_n
);

  phs_edge_t sel_p;
  phs_edge_t sel_n;
  phs_edge_t r_bin;
  phs_edge_t f_bin;

  function automatic gray_code_t gray_to_bin(input gray_code_t g);
    gray_code_t b;
    b[$bits(g)-1] = g[$bits(g)-1];
    for (int i = $bits(g) - 2; i >= 0; i--) begin
      b[i] = b[i+1] ^ g[i];
    end
    return b;
  endfunction

  assign sel_p = phy_clk_phs_ctrl ? c_in_n : c_in_p;
  assign sel_n = phy_clk_phs_ctrl ? c_in_p : c_in_n;

  assign r_bin = phs_edge_t'(gray_to_bin(r_gray));
  assign f_bin = phs_edge_t'(gray_to_bin(f_gray));

  // Wraps modulo the period
  assign c_out_p = cenable ? phs_edge_t'(sel_p + r_bin) : sel_p;
  assign c_out_n = cenable ? phs_edge_t'(sel_n + f_bin) : sel_n;

endmodule

// ==== io_phs_check.sv ====
// ==========================================================================
// Phase checker: registered neighbour spacing and pair duty flags
// ==========================================================================
`timescale 1ns/1ns
`include "phs_cal_macros.svh"

module io_phs_check
  import phs_types_pkg::*;
(
  input  logic       sample_clk,
  input  logic       rst_n,
  input  phs_vec_t   ph_in,
  output logic [7:0] ph_and_sample,
  output logic [3:0] ph_sample
);

  localparam phs_edge_t SPACE_MIN = phs_edge_t'(32);
  localparam phs_edge_t DUTY_MIN  = phs_edge_t'(128);

  logic [NUM_PHASES-1:0] space_ok;
  logic [`NUM_PAIRS-1:0] duty_ok;

  for (genvar i = 0; i < NUM_PHASES; i++) begin : g_space
    phs_edge_t gap;
    assign gap         = ph_in[(i + 1) % NUM_PHASES] - ph_in[i];
    assign space_ok[i] = (gap >= SPACE_MIN);
  end

  // High time of each pair, p edge to n edge
  for (genvar k = 0; k < `NUM_PAIRS; k++) begin : g_duty
    phs_edge_t high_w;
    assign high_w     = ph_in[k + `NUM_PAIRS] - ph_in[k];
    assign duty_ok[k] = (high_w >= DUTY_MIN);
  end

  always_ff @(posedge sample_clk) begin
    if (!rst_n) begin
      ph_and_sample <= '0;
      ph_sample     <= '0;
    end else begin
      ph_and_sample <= space_ok;
      ph_sample     <= duty_ok;
    end
  end

endmodule

// ==== io_8phs_calibrate.sv ====
// ==========================================================================
// Eight-phase calibrator: per-pair trim codes from the FIFO, registered
// calibrated phases out
// ==========================================================================
`timescale 1ns/1ns
`include "phs_cal_macros.svh"

module io_8phs_calibrate
  import phs_types_pkg::*;
(
  input  logic                  sample_clk,
  input  logic                  rst_n,
  input  phs_vec_t              phs_in,
  input  logic                  cenable,
  input  logic [`NUM_PAIRS-1:0] phy_clk_phs_ctrl,
  input  logic                  pop_valid,
  output logic                  pop_ready,
  input  trim_cmd_t             pop_data,
  output phs_vec_t              phs_calibrate
);

  gray_code_t [`NUM_PAIRS-1:0] r_code;
  gray_code_t [`NUM_PAIRS-1:0] f_code;
  phs_vec_t                    cal_d;

  for (genvar k = 0; k < `NUM_PAIRS; k++) begin : g_pair
    io_phs_pair_couple u_couple (
      .c_in_p           (phs_in[k]),
      .c_in_n           (phs_in[k + `NUM_PAIRS]),
      .phy_clk_phs_ctrl (phy_clk_phs_ctrl[k]),
      .cenable          (cenable),
      .r_gray           (r_code[k]),
      .f_gray           (f_code[k]),
      .c_out_p          (cal_d[k]),
      .c_out_n          (cal_d[k + `NUM_PAIRS])
    );
  end

  always_ff @(posedge sample_clk) begin
    if (!rst_n) begin
      pop_ready     <= 1'b0;
      r_code        <= '0;
      f_code        <= '0;
      phs_calibrate <= '0;
    end else begin
      // Always draining once out of reset
      pop_ready     <= 1'b1;
      phs_calibrate <= cal_d;
      if (pop_valid && pop_ready) begin
        r_code[pop_data.pair] <= pop_data.r_gray;
        f_code[pop_data.pair] <= pop_data.f_gray;
      end
    end
  end

endmodule

// ==== trim_fifo.sv ====
// ==========================================================================
// Trim command FIFO: synchronous circular buffer with valid/ready ports
// ==========================================================================
`timescale 1ns/1ns
`include "phs_cal_macros.svh"

module trim_fifo
  import phs_types_pkg::*;
#(
  parameter type T = trim_cmd_t
) (
  input  logic sample_clk,
  input  logic rst_n,
  input  logic push_valid,
  output logic push_ready,
  input  T     push_data,
  output logic pop_valid,
  input  logic pop_ready,
  output T     pop_data,
  output logic full
);

  localparam int DEPTH = `TRIM_FIFO_DEPTH;
  localparam int PTR_W = $clog2(DEPTH);
  localparam int CNT_W = $clog2(DEPTH + 1);

  T                 mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  logic             push_fire;
  logic             pop_fire;

  assign full       = (count == CNT_W'(DEPTH));
  assign push_ready = !full;
  assign pop_valid  = (count != '0);
  assign pop_data   = mem[rd_ptr];
  assign push_fire  = push_valid && push_ready;
  assign pop_fire   = pop_valid && pop_ready;

  always_ff @(posedge sample_clk) begin
    if (push_fire) mem[wr_ptr] <= push_data;
  end

  always_ff @(posedge sample_clk) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push_fire) wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      if (pop_fire) rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      case ({push_fire, pop_fire})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

endmodule

// ==== phs_cal_axil.sv ====
// ==========================================================================
// AXI4-Lite register slave: CTRL, TRIM push into the FIFO, STATUS readback
// ==========================================================================
`timescale 1ns/1ns
`include "phs_cal_macros.svh"

module phs_cal_axil
  import phs_types_pkg::*;
  import axil_types_pkg::*;
(
  input  logic                    sample_clk,
  input  logic                    rst_n,
  input  logic [`AXIL_ADDR_W-1:0] awaddr,
  input  logic                    awvalid,
  output logic                    awready,
  input  logic [31:0]             wdata,
  input  logic [3:0]              wstrb,
  input  logic                    wvalid,
  output logic                    wready,
  output axil_resp_t              bresp,
  output logic                    bvalid,
  input  logic                    bready,
  input  logic [`AXIL_ADDR_W-1:0] araddr,
  input  logic                    arvalid,
  output logic                    arready,
  output logic [31:0]             rdata,
  output axil_resp_t              rresp,
  output logic                    rvalid,
  input  logic                    rready,
  output logic                    push_valid,
  input  logic                    push_ready,
  output trim_cmd_t               push_data,
  input  logic                    fifo_full,
  input  logic [7:0]              phs_and_sample,
  input  logic [3:0]              phs_sample,
  output logic                    cenable,
  output logic [`NUM_PAIRS-1:0]   phy_clk_phs_ctrl
);

  logic        active;
  logic        wr_is_trim;
  logic        wr_is_ctrl;
  logic        strb_ok;
  logic        wr_fire;
  logic        rd_fire;
  axil_resp_t  wr_resp;
  axil_resp_t  rd_resp;
  logic [31:0] rd_word;

  assign wr_is_trim = (awaddr == REG_TRIM);
  assign wr_is_ctrl = (awaddr == REG_CTRL);
  assign strb_ok    = (wstrb == 4'hf);

  // Write side idle until B is taken, stalls a TRIM while the FIFO is full
  assign awready = active && !bvalid && (!wr_is_trim || push_ready);
  assign wready  = awready;
  assign wr_fire = awvalid && wvalid && awready;
  assign wr_resp = (strb_ok && (wr_is_ctrl || wr_is_trim)) ? OKAY : SLVERR;

  assign push_valid = active && !bvalid && awvalid && wvalid && wr_is_trim && strb_ok;
  assign push_data  = '{pair:   wdata[1:0],
                        r_gray: wdata[8 +: `GRAY_W],
                        f_gray: wdata[16 +: `GRAY_W]};

  assign arready = active && !rvalid;
  assign rd_fire = arvalid && arready;

  always_comb begin
    rd_word = '0;
    rd_resp = OKAY;
    case (araddr)
      REG_CTRL:   rd_word = {27'b0, phy_clk_phs_ctrl, cenable};
      REG_STATUS: rd_word = {15'b0, fifo_full, 4'b0, phs_sample, phs_and_sample};
      // TRIM is write only
      default:    rd_resp = SLVERR;
    endcase
  end

  always_ff @(posedge sample_clk) begin
    if (!rst_n) begin
      active           <= 1'b0;
      bvalid           <= 1'b0;
      bresp            <= OKAY;
      rvalid           <= 1'b0;
      rresp            <= OKAY;
      rdata            <= '0;
      cenable          <= 1'b0;
      phy_clk_phs_ctrl <= '0;
    end else begin
      active <= 1'b1;
      if (wr_fire) begin
        bvalid <= 1'b1;
        bresp  <= wr_resp;
        if (strb_ok && wr_is_ctrl) begin
          cenable          <= wdata[0];
          phy_clk_phs_ctrl <= wdata[4:1];
        end
      end else if (bready) begin
        bvalid <= 1'b0;
      end
      if (rd_fire) begin
        rvalid <= 1'b1;
        rresp  <= rd_resp;
        rdata  <= rd_word;
      end else if (rready) begin
        rvalid <= 1'b0;
      end
    end
  end

endmodule

// ==== phs_cal_top.sv ====
// ==========================================================================
// Phase calibration top: AXI slave, trim FIFO, calibrator and checker
// ==========================================================================
`timescale 1ns/1ns
`include "phs_cal_macros.svh"

module phs_cal_top
  import phs_types_pkg::*;
  import axil_types_pkg::*;
(
  input  logic                    sample_clk,
  input  logic                    rst_n,
  input  phs_vec_t                phs_in,
  input  logic [`AXIL_ADDR_W-1:0] awaddr,
  input  logic                    awvalid,
  output logic                    awready,
  input  logic [31:0]             wdata,
  input  logic [3:0]              wstrb,
  input  logic                    wvalid,
  output logic                    wready,
  output axil_resp_t              bresp,
  output logic                    bvalid,
  input  logic                    bready,
  input  logic [`AXIL_ADDR_W-1:0] araddr,
  input  logic                    arvalid,
  output logic                    arready,
  output logic [31:0]             rdata,
  output axil_resp_t              rresp,
  output logic                    rvalid,
  input  logic                    rready,
  output phs_vec_t                phs_calibrate,
  output logic [7:0]              phs_and_sample,
  output logic [3:0]              phs_sample
);

  logic                  push_valid;
  logic                  push_ready;
  trim_cmd_t             push_data;
  logic                  pop_valid;
  logic                  pop_ready;
  trim_cmd_t             pop_data;
  logic                  fifo_full;
  logic                  cenable;
  logic [`NUM_PAIRS-1:0] phy_clk_phs_ctrl;

  phs_cal_axil u_axil (
    .sample_clk, .rst_n,
    .awaddr, .awvalid, .awready, .wdata, .wstrb, .wvalid, .wready,
    .bresp, .bvalid, .bready,
    .araddr, .arvalid, .arready, .rdata, .rresp, .rvalid, .rready,
    .push_valid, .push_ready, .push_data,
    .fifo_full, .phs_and_sample, .phs_sample,
    .cenable, .phy_clk_phs_ctrl
  );

  trim_fifo #(.T(trim_cmd_t)) u_fifo (
    .sample_clk, .rst_n,
    .push_valid, .push_ready, .push_data,
    .pop_valid, .pop_ready, .pop_data,
    .full (fifo_full)
  );

  io_8phs_calibrate u_cal (
    .sample_clk, .rst_n, .phs_in,
    .cenable, .phy_clk_phs_ctrl,
    .pop_valid, .pop_ready, .pop_data,
    .phs_calibrate
  );

  io_phs_check u_check (
    .sample_clk,
    .rst_n,
    .ph_in         (phs_calibrate),
    .ph_and_sample (phs_and_sample),
    .ph_sample     (phs_sample)
  );

endmodule

// ==== phs_cal_sva.sv ====
// ==========================================================================
// Assertions on the AXI4-Lite responses and the trim FIFO, attached by bind
// ==========================================================================
`timescale 1ns/1ns

module phs_cal_sva (
  input logic       clk,
  input logic       rst_n,
  input logic [1:0] resp_valid,
  input logic [1:0] resp_ready,
  input logic       push_fire,
  input logic       pop_fire,
  input logic       full,
  input logic       empty,
  input logic [2:0] out_valid
);

  int   fail_count;
  // Reset was low at the previous edge
  logic rst_q;

  initial fail_count = 0;

  always_ff @(posedge clk) begin
    rst_q <= !rst_n;
  end

  a_b_hold: assert property (@(posedge clk) disable iff (!rst_n)
    resp_valid[0] && !resp_ready[0] |=> resp_valid[0])
    else begin
      fail_count++;
      $error("bvalid dropped before bready");
    end

  a_r_hold: assert property (@(posedge clk) disable iff (!rst_n)
    resp_valid[1] && !resp_ready[1] |=> resp_valid[1])
    else begin
      fail_count++;
      $error("rvalid dropped before rready");
    end

  // A full FIFO that is not drained takes nothing more
  a_no_push_full: assert property (@(posedge clk) disable iff (!rst_n)
    full && !pop_fire |=> full)
    else begin
      fail_count++;
      $error("FIFO push while full");
    end

  // An empty FIFO that is not filled gives nothing out
  a_no_pop_empty: assert property (@(posedge clk) disable iff (!rst_n)
    empty && !push_fire |=> empty)
    else begin
      fail_count++;
      $error("FIFO pop while empty");
    end

  a_quiet_in_reset: assert property (@(posedge clk)
    rst_q && !rst_n |-> out_valid == '0)
    else begin
      fail_count++;
      $error("Valid output high during reset");
    end

endmodule

bind phs_cal_axil phs_cal_sva u_axil_sva (
  .clk        (sample_clk),
  .rst_n      (rst_n),
  .resp_valid ({rvalid, bvalid}),
  .resp_ready ({rready, bready}),
  .push_fire  (1'b0),
  .pop_fire   (1'b0),
  .full       (1'b0),
  .empty      (1'b0),
  .out_valid  ({bvalid, rvalid, push_valid})
);

bind trim_fifo phs_cal_sva u_fifo_sva (
  .clk        (sample_clk),
  .rst_n      (rst_n),
  .resp_valid (2'b00),
  .resp_ready (2'b11),
  .push_fire  (push_fire),
  .pop_fire   (pop_fire),
  .full       (full),
  .empty      (count == '0),
  .out_valid  ({2'b00, pop_valid})
);

// ==== tb_phs_cal.sv ====
// ==========================================================================
// Testbench for the phase calibration top: AXI register traffic and phases
// ==========================================================================
`timescale 1ns/1ns
`include "phs_cal_macros.svh"

module tb_phs_cal
  import phs_types_pkg::*;
  import axil_types_pkg::*;
();

  // Tests take about 300 cycles
  localparam int MAX_CYCLES = 2000;

  logic                    sample_clk;
  logic                    rst_n;
  phs_vec_t                phs_in;
  logic [`AXIL_ADDR_W-1:0] awaddr;
  logic [`AXIL_ADDR_W-1:0] araddr;
  logic [31:0]             wdata;
  logic [3:0]              wstrb;
  logic                    awvalid, wvalid, bready, arvalid, rready;
  logic                    awready, wready, bvalid, arready, rvalid;
  axil_resp_t              bresp, rresp;
  logic [31:0]             rdata;
  phs_vec_t                phs_calibrate;
  logic [7:0]              phs_and_sample;
  logic [3:0]              phs_sample;

  integer      seed = 15317;
  int          cycles;
  int          sva_fails;
  gray_code_t  model_r [`NUM_PAIRS];
  gray_code_t  model_f [`NUM_PAIRS];
  logic        model_cen;
  logic [3:0]  model_swap;
  axil_resp_t  resp;
  logic [31:0] word;
  phs_vec_t    vec;

  phs_cal_top dut0 (.*);

  initial begin
    sample_clk = 1'b0;
    forever #2 sample_clk = ~sample_clk;
  end

  initial begin
    cycles = 0;
    forever begin
      @(posedge sample_clk);
      cycles++;
      if (cycles >= MAX_CYCLES) begin
        $display("Timeout: run did not finish within %0d cycles", MAX_CYCLES);
        $display("Some tests failed");
        $fatal(1, "Watchdog expired");
      end
    end
  end

  function automatic phs_edge_t gray_to_binary(input gray_code_t g);
    gray_code_t b;
    b = g;
    for (int s = 1; s < `GRAY_W; s++) begin
      b = b ^ (g >> s);
    end
    return phs_edge_t'(b);
  endfunction

  // Swap, then trim each member of a pair
  function automatic phs_vec_t expect_cal(input phs_vec_t v);
    phs_vec_t  e;
    phs_edge_t p;
    phs_edge_t n;
    for (int k = 0; k < `NUM_PAIRS; k++) begin
      p = model_swap[k] ? v[k + 4] : v[k];
      n = model_swap[k] ? v[k] : v[k + 4];
      e[k]     = model_cen ? p + gray_to_binary(model_r[k]) : p;
      e[k + 4] = model_cen ? n + gray_to_binary(model_f[k]) : n;
    end
    return e;
  endfunction

  function automatic logic [7:0] expect_space(input phs_vec_t v);
    logic [7:0] f;
    phs_edge_t  d;
    for (int i = 0; i < 8; i++) begin
      d    = v[(i + 1) % 8] - v[i];
      f[i] = (d >= 8'd32);
    end
    return f;
  endfunction

  function automatic logic [3:0] expect_duty(input phs_vec_t v);
    logic [3:0] f;
    phs_edge_t  d;
    for (int k = 0; k < 4; k++) begin
      d    = v[k + 4] - v[k];
      f[k] = (d >= 8'd128);
    end
    return f;
  endfunction

  task automatic fail_now(input string what);
    $display("%s", what);
    $display("Some tests failed");
    $fatal(1, "Stopped at first error");
  endtask

  task automatic check_vec(input string name, input phs_vec_t got, input phs_vec_t want);
    if (got !== want)
      fail_now($sformatf("Mismatch %s: got 0x%h expected 0x%h", name, got, want));
  endtask

  task automatic check_flags(input logic [7:0] got_space, input logic [7:0] want_space,
                             input logic [3:0] got_duty, input logic [3:0] want_duty);
    if (got_space !== want_space)
      fail_now($sformatf("Mismatch phs_and_sample: got 0x%h expected 0x%h",
                         got_space, want_space));
    if (got_duty !== want_duty)
      fail_now($sformatf("Mismatch phs_sample: got 0x%h expected 0x%h", got_duty, want_duty));
  endtask

  task automatic check_resp(input string name, input axil_resp_t got, input axil_resp_t want);
    if (got !== want)
      fail_now($sformatf("Mismatch %s: got 0x%h expected 0x%h", name, got, want));
  endtask

  task automatic check_word(input string name, input logic [31:0] got, input logic [31:0] want);
    if (got !== want)
      fail_now($sformatf("Mismatch %s: got 0x%h expected 0x%h", name, got, want));
  endtask

  task automatic axil_write(input logic [3:0] addr, input logic [31:0] data,
                            output axil_resp_t r);
    @(negedge sample_clk);
    awaddr  = addr;
    wdata   = data;
    wstrb   = 4'hf;
    awvalid = 1'b1;
    wvalid  = 1'b1;
    #1;
    while (!(awready && wready)) begin
      @(negedge sample_clk);
      #1;
    end
    @(negedge sample_clk);
    awvalid = 1'b0;
    wvalid  = 1'b0;
    while (!bvalid) @(negedge sample_clk);
    r      = bresp;
    bready = 1'b1;
    @(negedge sample_clk);
    bready = 1'b0;
  endtask

  task automatic axil_read(input logic [3:0] addr, output logic [31:0] data,
                           output axil_resp_t r);
    @(negedge sample_clk);
    araddr  = addr;
    arvalid = 1'b1;
    #1;
    while (!arready) begin
      @(negedge sample_clk);
      #1;
    end
    @(negedge sample_clk);
    arvalid = 1'b0;
    while (!rvalid) @(negedge sample_clk);
    data   = rdata;
    r      = rresp;
    rready = 1'b1;
    @(negedge sample_clk);
    rready = 1'b0;
  endtask

  task automatic write_ctrl(input logic cen, input logic [3:0] swap);
    axil_write(REG_CTRL, {27'b0, swap, cen}, resp);
    check_resp("bresp CTRL", resp, OKAY);
    model_cen  = cen;
    model_swap = swap;
  endtask

  // Codes are given in binary and sent gray coded
  task automatic write_trim(input logic [1:0] pair, input gray_code_t r_bin,
                            input gray_code_t f_bin);
    logic [31:0] data;
    data        = '0;
    data[1:0]   = pair;
    data[13:8]  = r_bin ^ (r_bin >> 1);
    data[21:16] = f_bin ^ (f_bin >> 1);
    axil_write(REG_TRIM, data, resp);
    check_resp("bresp TRIM", resp, OKAY);
    model_r[pair] = data[13:8];
    model_f[pair] = data[21:16];
  endtask

  task automatic draw_phases(output phs_vec_t v);
    for (int k = 0; k < 8; k++) begin
      v[k] = phs_edge_t'($random(seed));
    end
  endtask

  task automatic drive_phases(input phs_vec_t v, input int wait_cycles);
    @(negedge sample_clk);
    phs_in = v;
    repeat (wait_cycles) @(negedge sample_clk);
  endtask

  task automatic check_phases();
    phs_vec_t e;
    e = expect_cal(phs_in);
    check_vec("phs_calibrate", phs_calibrate, e);
    check_flags(phs_and_sample, expect_space(e), phs_sample, expect_duty(e));
  endtask

  // Handshake outputs low in reset, readies up one edge after release
  task automatic reset_values();
    repeat (8) @(posedge sample_clk);
    @(negedge sample_clk);
    check_word("awready/wready/arready/bvalid/rvalid",
               {27'b0, awready, wready, arready, bvalid, rvalid}, 32'h00);
    rst_n = 1'b1;
    @(negedge sample_clk);
    check_word("awready/wready/arready/bvalid/rvalid",
               {27'b0, awready, wready, arready, bvalid, rvalid}, 32'h1c);
    check_vec("phs_calibrate", phs_calibrate, '0);
    check_flags(phs_and_sample, 8'h00, phs_sample, 4'h0);
    axil_read(REG_CTRL, word, resp);
    check_resp("rresp CTRL", resp, OKAY);
    check_word("rdata CTRL", word, 32'h0);
    axil_read(REG_STATUS, word, resp);
    check_resp("rresp STATUS", resp, OKAY);
    check_word("rdata STATUS", word, 32'h0);
  endtask

  task automatic bypass_when_disabled();
    write_ctrl(1'b0, 4'h0);
    for (int k = 0; k < 4; k++) begin
      write_trim(2'(k), gray_code_t'($random(seed)), gray_code_t'($random(seed)));
    end
    repeat (4) begin
      draw_phases(vec);
      drive_phases(vec, 2);
      check_vec("phs_calibrate", phs_calibrate, phs_in);
    end
  endtask

  task automatic trim_per_pair();
    write_ctrl(1'b1, 4'h0);
    for (int k = 0; k < 4; k++) begin
      write_trim(2'(k), gray_code_t'($random(seed)), gray_code_t'($random(seed)));
    end
    repeat (4) begin
      draw_phases(vec);
      drive_phases(vec, 2);
      check_phases();
    end
  endtask

  task automatic swap_each_pair();
    for (int k = 0; k < 4; k++) begin
      write_ctrl(1'b1, 4'b1 << k);
      draw_phases(vec);
      drive_phases(vec, 2);
      check_phases();
    end
    write_ctrl(1'b0, 4'hf);
    draw_phases(vec);
    drive_phases(vec, 2);
    check_phases();
  endtask

  task automatic flags_and_status();
    phs_vec_t e;
    write_ctrl(1'b1, 4'h5);
    repeat (6) begin
      draw_phases(vec);
      drive_phases(vec, 6);
      check_phases();
      e = expect_cal(phs_in);
      axil_read(REG_STATUS, word, resp);
      check_resp("rresp STATUS", resp, OKAY);
      check_word("rdata STATUS", word, {20'b0, expect_duty(e), expect_space(e)});
    end
  endtask

  task automatic burst_and_errors();
    write_ctrl(1'b1, 4'h0);
    for (int n = 0; n < 6; n++) begin
      write_trim(2'(n % 4), gray_code_t'($random(seed)), gray_code_t'($random(seed)));
    end
    draw_phases(vec);
    drive_phases(vec, 2);
    check_phases();
    axil_read(4'hc, word, resp);
    check_resp("rresp unmapped", resp, SLVERR);
    axil_read(REG_TRIM, word, resp);
    check_resp("rresp TRIM", resp, SLVERR);
    axil_write(REG_STATUS, 32'hffff_ffff, resp);
    check_resp("bresp STATUS", resp, SLVERR);
    axil_read(REG_CTRL, word, resp);
    check_resp("rresp CTRL", resp, OKAY);
    check_word("rdata CTRL", word, 32'h1);
  endtask

  initial begin
    rst_n   = 1'b0;
    phs_in  = '0;
    awaddr  = '0;
    araddr  = '0;
    wdata   = '0;
    wstrb   = '0;
    awvalid = 1'b0;
    wvalid  = 1'b0;
    bready  = 1'b0;
    arvalid = 1'b0;
    rready  = 1'b0;
    model_cen  = 1'b0;
    model_swap = '0;
    for (int k = 0; k < `NUM_PAIRS; k++) begin
      model_r[k] = '0;
      model_f[k] = '0;
    end
    reset_values();
    bypass_when_disabled();
    trim_per_pair();
    swap_each_pair();
    flags_and_status();
    burst_and_errors();
    sva_fails = dut0.u_axil.u_axil_sva.fail_count + dut0.u_fifo.u_fifo_sva.fail_count;
    if (sva_fails == 0) begin
      $display("All tests passed");
    end else begin
      $display("Assertion failures seen: %0d", sva_fails);
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

// ==== phs_cal_top.f ====
+incdir+.
phs_types_pkg.sv
axil_types_pkg.sv
io_phs_pair_couple.sv
io_phs_check.sv
io_8phs_calibrate.sv
trim_fifo.sv
phs_cal_axil.sv
phs_cal_top.sv
phs_cal_sva.sv
tb_phs_cal.sv

// ==== Makefile ====
.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -sv -f phs_cal_top.f --top-module tb_phs_cal -o sim_phs_cal

run: compile
	./obj_dir/sim_phs_cal +verilator+error+limit+100 > sim.log 2>&1; cat sim.log
	grep -q "All tests passed" sim.log

clean:
	rm -rf obj_dir sim.log
